//--- sipoPkg.sv
`default_nettype none

package sipoPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data path widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // bit address = byte address and lane select.
    localparam int BitAddrWidth  = 13;
    localparam int ByteAddrWidth = 10;
    localparam int LaneSelWidth  = 3;
    localparam int ByteWidth     = 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int RegAddrWidth = 2;
    localparam int RegDataWidth = 16;

    // frame length in bytes minus one.
    localparam logic [RegAddrWidth-1:0] RegFrameLen = 2'd0;
    // read only.
    localparam logic [RegAddrWidth-1:0] RegStatus   = 2'd1;
    // any write aborts the frame.
    localparam logic [RegAddrWidth-1:0] RegClear    = 2'd2;

    // status word layout.
    localparam int StatusFullBit  = 0;
    localparam int StatusBusyBit  = 1;
    localparam int StatusCountLsb = 2;

endpackage

`default_nettype wire

//--- sipoMemIf.sv
`timescale 1ns/1ns
`default_nettype none

interface sipoMemIf
    import sipoPkg::*;
();

    // write side, one bit per enable.
    logic [BitAddrWidth-1:0]  wrAddr;
    logic                     wrData;
    logic                     wrEn;

    // read side, registered byte output.
    logic [ByteAddrWidth-1:0] rdAddr;
    logic                     nRdClkEn;
    logic [ByteWidth-1:0]     rdData;

    modport writer
    (
        output wrAddr,
        output wrData,
        output wrEn
    );

    modport reader
    (
        output rdAddr,
        output nRdClkEn,
        input  rdData
    );

    modport store
    (
        input  wrAddr,
        input  wrData,
        input  wrEn,
        input  rdAddr,
        input  nRdClkEn,
        output rdData
    );

endinterface

`default_nettype wire

//--- ram1k1.sv
`timescale 1ns/1ns
`default_nettype none

module ram1k1
    import sipoPkg::*;
(
    input  logic                     MCLK,

    input  logic [ByteAddrWidth-1:0] rdAddr,
    input  logic [ByteAddrWidth-1:0] wrAddr,
    input  logic                     din,
    output logic                     dout,
    input  logic                     we,
    input  logic                     nRdClkEn,
    input  logic                     nWrClkEn
);

    localparam int Depth = 2 ** ByteAddrWidth;

    logic mem [0:Depth-1];

    // write port.
    always_ff @(posedge MCLK)
    begin
        if (we && !nWrClkEn)
        begin
            mem[wrAddr] <= din;
        end
    end

    // read port, output holds while disabled.
    always_ff @(posedge MCLK)
    begin
        if (!nRdClkEn)
        begin
            dout <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

//--- sipoBuffer.sv
`timescale 1ns/1ns
`default_nettype none

module sipoBuffer
    import sipoPkg::*;
(
    input  logic   MCLK,

    sipoMemIf.store mem
);

    // one-hot low, D7 D6 D5 D4 D3 D2 D1 D0.
    logic [ByteWidth-1:0] laneSelN;
    wire  [ByteWidth-1:0] laneOut;
    wire                  nWrClkEn;

    assign nWrClkEn = ~mem.wrEn;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write lane decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // first bit of a byte lands in D7.
    always_comb
    begin
        case (mem.wrAddr[LaneSelWidth-1:0])
            3'b000:  laneSelN = 8'b0111_1111;
            3'b001:  laneSelN = 8'b1011_1111;
            3'b010:  laneSelN = 8'b1101_1111;
            3'b011:  laneSelN = 8'b1110_1111;
            3'b100:  laneSelN = 8'b1111_0111;
            3'b101:  laneSelN = 8'b1111_1011;
            3'b110:  laneSelN = 8'b1111_1101;
            3'b111:  laneSelN = 8'b1111_1110;
            default: laneSelN = 8'b1111_1111;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane rams
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // all lanes share the byte address.
    for (genvar i = 0; i < ByteWidth; i++)
    begin : gLane
        ram1k1 uLane
        (
            .MCLK     (MCLK                                   ),
            .rdAddr   (mem.rdAddr                             ),
            .wrAddr   (mem.wrAddr[BitAddrWidth-1:LaneSelWidth]),
            .din      (mem.wrData                             ),
            .dout     (laneOut[i]                             ),
            .we       (~laneSelN[i]                           ),
            .nRdClkEn (mem.nRdClkEn                           ),
            .nWrClkEn (nWrClkEn                               )
        );
    end

    assign mem.rdData = laneOut;

endmodule

`default_nettype wire

//--- sipoWriter.sv
`timescale 1ns/1ns
`default_nettype none

module sipoWriter
    import sipoPkg::*;
#(
    parameter int FrameMax = 1024
)
(
    input  logic                     MCLK,
    input  logic                     rstN,

    input  logic                     bitValid,
    input  logic                     bitData,
    output logic                     bitReady,

    input  logic [ByteAddrWidth-1:0] frameLen,
    input  logic                     clear,
    input  logic                     frameDone,
    output logic                     frameFull,
    output logic [ByteAddrWidth-1:0] byteCount,

    sipoMemIf.writer                 mem
);

    localparam logic [ByteAddrWidth-1:0] LastByte = ByteAddrWidth'(FrameMax - 1);

    logic [BitAddrWidth-1:0]  bitCnt;
    logic [ByteAddrWidth-1:0] lenClamped;
    logic [BitAddrWidth-1:0]  lastBit;
    logic                     accept;

    // frame cannot exceed the store.
    assign lenClamped = (frameLen > LastByte) ? LastByte : frameLen;
    assign lastBit    = {lenClamped, {LaneSelWidth{1'b1}}};
    assign accept     = bitValid && bitReady;

    // bit counter doubles as write address.
    assign mem.wrAddr = bitCnt;
    assign mem.wrData = bitData;
    assign mem.wrEn   = accept;

    assign byteCount = bitCnt[BitAddrWidth-1:LaneSelWidth];

    always_ff @(posedge MCLK)
    begin
        if (!rstN)
        begin
            bitCnt    <= '0;
            frameFull <= 1'b0;
            bitReady  <= 1'b0;
        end
        else if (clear || frameDone)
        begin
            bitCnt    <= '0;
            frameFull <= 1'b0;
            bitReady  <= 1'b1;
        end
        else if (accept)
        begin
            bitCnt <= bitCnt + 1'b1;
            // last bit of the frame.
            if (bitCnt == lastBit)
            begin
                frameFull <= 1'b1;
                bitReady  <= 1'b0;
            end
        end
        else
        begin
            bitReady <= ~frameFull;
        end
    end

endmodule

`default_nettype wire

//--- sipoReader.sv
`timescale 1ns/1ns
`default_nettype none

module sipoReader
    import sipoPkg::*;
#(
    parameter int FrameMax = 1024
)
(
    input  logic                     MCLK,
    input  logic                     rstN,

    input  logic                     frameFull,
    input  logic [ByteAddrWidth-1:0] frameLen,
    input  logic                     clear,

    output logic                     byteValid,
    output logic [ByteWidth-1:0]     byteData,
    input  logic                     byteReady,
    output logic                     frameDone,

    sipoMemIf.reader                 mem
);

    localparam logic [ByteAddrWidth-1:0] LastByte = ByteAddrWidth'(FrameMax - 1);

    localparam logic [1:0] StIdle   = 2'd0;
    localparam logic [1:0] StPrime  = 2'd1;
    localparam logic [1:0] StStream = 2'd2;

    logic [1:0]               state;
    logic [ByteAddrWidth-1:0] addrCnt;
    logic [ByteAddrWidth-1:0] lenClamped;
    logic [ByteAddrWidth-1:0] endAddr;
    logic                     lastByte;
    logic                     xfer;

    assign lenClamped = (frameLen > LastByte) ? LastByte : frameLen;
    // addrCnt runs one ahead of the byte on the output.
    assign endAddr    = lenClamped + 1'b1;
    assign lastByte   = (addrCnt == endAddr);

    assign byteValid = (state == StStream);
    assign byteData  = mem.rdData;
    assign xfer      = byteValid && byteReady;

    assign mem.rdAddr = addrCnt;

    // ram output is the holding register.
    always_comb
    begin
        case (state)
            StPrime:  mem.nRdClkEn = 1'b0;
            StStream: mem.nRdClkEn = ~(byteReady && !lastByte);
            default:  mem.nRdClkEn = 1'b1;
        endcase
    end

    always_ff @(posedge MCLK)
    begin
        if (!rstN)
        begin
            state     <= StIdle;
            addrCnt   <= '0;
            frameDone <= 1'b0;
        end
        else
        begin
            frameDone <= 1'b0;
            if (clear)
            begin
                state   <= StIdle;
                addrCnt <= '0;
            end
            else
            begin
                case (state)
                    StIdle:
                    begin
                        // frameFull is still high while frameDone pulses.
                        if (frameFull && !frameDone)
                        begin
                            state   <= StPrime;
                            addrCnt <= '0;
                        end
                    end
                    StPrime:
                    begin
                        state   <= StStream;
                        addrCnt <= addrCnt + 1'b1;
                    end
                    StStream:
                    begin
                        if (xfer && lastByte)
                        begin
                            state     <= StIdle;
                            frameDone <= 1'b1;
                        end
                        else if (xfer)
                        begin
                            addrCnt <= addrCnt + 1'b1;
                        end
                    end
                    default:
                    begin
                        state <= StIdle;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- sipoCtrlRegs.sv
`timescale 1ns/1ns
`default_nettype none

module sipoCtrlRegs
    import sipoPkg::*;
(
    input  logic                     MCLK,
    input  logic                     rstN,

    input  logic                     regWrEn,
    input  logic [RegAddrWidth-1:0]  regAddr,
    input  logic [RegDataWidth-1:0]  regWrData,
    output logic [RegDataWidth-1:0]  regRdData,

    output logic [ByteAddrWidth-1:0] frameLen,
    output logic                     clear,

    input  logic                     frameFull,
    input  logic                     readerBusy,
    input  logic [ByteAddrWidth-1:0] byteCount
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register writes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge MCLK)
    begin
        if (!rstN)
        begin
            frameLen <= '0;
            clear    <= 1'b0;
        end
        else
        begin
            // single cycle abort.
            clear <= regWrEn && (regAddr == RegClear);
            if (regWrEn && (regAddr == RegFrameLen))
            begin
                frameLen <= regWrData[ByteAddrWidth-1:0];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // readback
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        regRdData = '0;
        case (regAddr)
            RegFrameLen:
            begin
                regRdData[ByteAddrWidth-1:0] = frameLen;
            end
            RegStatus:
            begin
                regRdData[StatusFullBit]                  = frameFull;
                regRdData[StatusBusyBit]                  = readerBusy;
                regRdData[StatusCountLsb +: ByteAddrWidth] = byteCount;
            end
            default:
            begin
                regRdData = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- sipoTop.sv
`timescale 1ns/1ns
`default_nettype none

module sipoTop
    import sipoPkg::*;
#(
    parameter int FrameMax = 1024
)
(
    input  logic                    MCLK,
    input  logic                    rstN,

    // serial input.
    input  logic                    bitValid,
    input  logic                    bitData,
    output logic                    bitReady,

    // byte output.
    output logic                    byteValid,
    output logic [ByteWidth-1:0]    byteData,
    input  logic                    byteReady,

    // register port.
    input  logic                    regWrEn,
    input  logic [RegAddrWidth-1:0] regAddr,
    input  logic [RegDataWidth-1:0] regWrData,
    output logic [RegDataWidth-1:0] regRdData
);

    logic [ByteAddrWidth-1:0] frameLen;
    logic [ByteAddrWidth-1:0] byteCount;
    logic                     clear;
    logic                     frameFull;
    logic                     frameDone;

    sipoMemIf memBus ();

    sipoCtrlRegs uRegs
    (
        .MCLK       (MCLK      ),
        .rstN       (rstN      ),
        .regWrEn    (regWrEn   ),
        .regAddr    (regAddr   ),
        .regWrData  (regWrData ),
        .regRdData  (regRdData ),
        .frameLen   (frameLen  ),
        .clear      (clear     ),
        .frameFull  (frameFull ),
        .readerBusy (byteValid ),
        .byteCount  (byteCount )
    );

    sipoWriter #(.FrameMax(FrameMax)) uWriter
    (
        .MCLK      (MCLK             ),
        .rstN      (rstN             ),
        .bitValid  (bitValid         ),
        .bitData   (bitData          ),
        .bitReady  (bitReady         ),
        .frameLen  (frameLen         ),
        .clear     (clear            ),
        .frameDone (frameDone        ),
        .frameFull (frameFull        ),
        .byteCount (byteCount        ),
        .mem       (memBus.writer    )
    );

    sipoReader #(.FrameMax(FrameMax)) uReader
    (
        .MCLK      (MCLK             ),
        .rstN      (rstN             ),
        .frameFull (frameFull        ),
        .frameLen  (frameLen         ),
        .clear     (clear            ),
        .byteValid (byteValid        ),
        .byteData  (byteData         ),
        .byteReady (byteReady        ),
        .frameDone (frameDone        ),
        .mem       (memBus.reader    )
    );

    sipoBuffer uBuffer
    (
        .MCLK (MCLK        ),
        .mem  (memBus.store)
    );

endmodule

`default_nettype wire

//--- tbSipoTop.sv
`timescale 1ns/1ns
`default_nettype none

module tbSipoTop
    import sipoPkg::*;
();

    localparam int GoldenDepth = 64;
    localparam int ClkHalf     = 2;

    logic                    MCLK;
    logic                    rstN;
    logic                    bitValid;
    logic                    bitData;
    logic                    bitReady;
    logic                    byteValid;
    logic [ByteWidth-1:0]    byteData;
    logic                    byteReady;
    logic                    regWrEn;
    logic [RegAddrWidth-1:0] regAddr;
    logic [RegDataWidth-1:0] regWrData;
    logic [RegDataWidth-1:0] regRdData;

    logic [15:0]          golden [0:GoldenDepth-1];
    logic [ByteWidth-1:0] stimQ [$];
    logic [ByteWidth-1:0] expQ [$];
    integer               seed;
    int                   errors;
    int                   checks;
    int                   watchdogNs;

    sipoTop #(.FrameMax(1024)) uut
    (
        .MCLK      (MCLK     ),
        .rstN      (rstN     ),
        .bitValid  (bitValid ),
        .bitData   (bitData  ),
        .bitReady  (bitReady ),
        .byteValid (byteValid),
        .byteData  (byteData ),
        .byteReady (byteReady),
        .regWrEn   (regWrEn  ),
        .regAddr   (regAddr  ),
        .regWrData (regWrData),
        .regRdData (regRdData)
    );

    initial
    begin
        MCLK = 1'b0;
        forever #ClkHalf MCLK = ~MCLK;
    end

    initial
    begin
        wait (watchdogNs != 0);
        #(watchdogNs);
        $display("Timeout: the run did not finish within %0d ns", watchdogNs);
        $display("Regression failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checking helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic compareValue(input string sigName, input logic [15:0] expVal,
                                input logic [15:0] actVal);
        checks++;
        assert (actVal === expVal)
        else
        begin
            errors++;
            $display("[ERROR] %0t ns: %s expected %0h, got %0h", $time, sigName, expVal, actVal);
        end
    endtask

    task automatic checkCondition(input bit cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            errors++;
            $display("ERROR at %0t ns: %s", $time, what);
        end
    endtask

    function automatic logic [15:0] goldenWord(input int idx);
        return golden[idx[5:0]];
    endfunction

    // fill pattern over the whole byte address.
    function automatic logic [7:0] fillByte(input int idx);
        logic [9:0] a;
        a = idx[9:0];
        return a[7:0] ^ {4{a[9:8]}} ^ 8'h5a;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic writeReg(input logic [RegAddrWidth-1:0] addr, input logic [15:0] data);
        regWrEn   = 1'b1;
        regAddr   = addr;
        regWrData = data;
        @(posedge MCLK);
        #1;
        regWrEn   = 1'b0;
        regAddr   = RegStatus;
        regWrData = '0;
    endtask

    task automatic sendBit(input logic b);
        logic taken;
        taken = 1'b0;
        // random idle cycles.
        while (($random(seed) & 3) == 0)
        begin
            @(posedge MCLK);
            #1;
        end
        bitValid = 1'b1;
        bitData  = b;
        while (!taken)
        begin
            @(negedge MCLK);
            taken = bitReady;
            @(posedge MCLK);
            #1;
        end
        bitValid = 1'b0;
        bitData  = 1'b0;
    endtask

    task automatic sendFrame();
        logic [7:0] shifter;
        int         sent;
        sent = 0;
        foreach (stimQ[i])
        begin
            shifter = stimQ[i];
            // msb goes out first.
            repeat (ByteWidth)
            begin
                sendBit(shifter[7]);
                shifter = {shifter[6:0], 1'b0};
            end
            sent++;
            @(negedge MCLK);
            compareValue("byteCount", 16'(sent[9:0]),
                         16'(regRdData[StatusCountLsb +: ByteAddrWidth]));
            @(posedge MCLK);
            #1;
        end
    endtask

    task automatic recvFrame();
        int         idx;
        logic       held;
        logic [7:0] heldData;
        idx      = 0;
        held     = 1'b0;
        heldData = '0;
        while (idx < expQ.size())
        begin
            byteReady = (($random(seed) & 3) != 0);
            @(negedge MCLK);
            // stalled byte must not move.
            if (held)
            begin
                compareValue("byteValid", 16'(1'b1), 16'(byteValid));
                compareValue("byteData", 16'(heldData), 16'(byteData));
            end
            if (byteValid)
            begin
                compareValue("bitReady", 16'(1'b0), 16'(bitReady));
                compareValue("status.frameFull", 16'(1'b1), 16'(regRdData[StatusFullBit]));
                compareValue("status.readerBusy", 16'(1'b1), 16'(regRdData[StatusBusyBit]));
                if (byteReady)
                begin
                    compareValue("byteData", 16'(expQ[idx]), 16'(byteData));
                    idx++;
                end
            end
            held     = byteValid && !byteReady;
            heldData = byteData;
            @(posedge MCLK);
            #1;
        end
        byteReady = 1'b0;
    endtask

    task automatic runFrame(input logic [9:0] lenMinus1);
        logic back;
        back = 1'b0;
        writeReg(RegFrameLen, 16'(lenMinus1));
        // length register reads back.
        regAddr = RegFrameLen;
        @(negedge MCLK);
        compareValue("frameLen", 16'(lenMinus1), regRdData);
        @(posedge MCLK);
        #1;
        regAddr = RegStatus;
        fork
            sendFrame();
            recvFrame();
        join
        // frameDone reopens the writer.
        for (int i = 0; i < 4 && !back; i++)
        begin
            @(negedge MCLK);
            back = bitReady;
            @(posedge MCLK);
            #1;
        end
        checkCondition(back, "bitReady did not return after the frame was read out");
    endtask

    task automatic runAbort(input logic [9:0] lenMinus1, input int nBytes);
        writeReg(RegFrameLen, 16'(lenMinus1));
        for (int i = 0; i < nBytes; i++)
        begin
            stimQ.push_back(fillByte(i));
        end
        sendFrame();
        // a full frame waits until the reader presents data.
        if (nBytes == int'(lenMinus1) + 1)
        begin
            @(negedge MCLK);
            while (!byteValid)
            begin
                @(negedge MCLK);
            end
            @(posedge MCLK);
            #1;
        end
        writeReg(RegClear, 16'h0000);
        @(posedge MCLK);
        #1;
        @(negedge MCLK);
        compareValue("byteValid", 16'(1'b0), 16'(byteValid));
        compareValue("byteCount", 16'h0000, 16'(regRdData[StatusCountLsb +: ByteAddrWidth]));
        compareValue("status.frameFull", 16'(1'b0), 16'(regRdData[StatusFullBit]));
        @(posedge MCLK);
        #1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial
    begin
        int          ptr;
        int          len;
        int          bits;
        logic [15:0] word;
        logic [15:0] entry;
        bit          stop;

        rstN       = 1'b0;
        bitValid   = 1'b0;
        bitData    = 1'b0;
        byteReady  = 1'b0;
        regWrEn    = 1'b0;
        regAddr    = RegStatus;
        regWrData  = '0;
        seed       = 32'heeb7_e8c4;
        errors     = 0;
        checks     = 0;
        watchdogNs = 0;

        $readmemh("sipo_golden.txt", golden);

        // total bit count sets the time budget.
        ptr  = 0;
        bits = 0;
        stop = 1'b0;
        while (!stop && ptr < GoldenDepth - 1)
        begin
            word = goldenWord(ptr);
            len  = int'(word[9:0]) + 1;
            case (word[15:12])
                4'h0:
                begin
                    bits += len * 8;
                    ptr  += len + 1;
                end
                4'h1:
                begin
                    bits += len * 8;
                    ptr  += 1;
                end
                4'h2:
                begin
                    bits += int'(goldenWord(ptr + 1)) * 8;
                    ptr  += 2;
                end
                default:
                begin
                    stop = 1'b1;
                end
            endcase
        end
        watchdogNs = bits * 40 + 2000;

        repeat (3) @(posedge MCLK);
        #1;
        rstN = 1'b1;
        @(posedge MCLK);
        #1;
        @(negedge MCLK);
        compareValue("bitReady", 16'(1'b1), 16'(bitReady));
        compareValue("byteValid", 16'(1'b0), 16'(byteValid));
        compareValue("status.frameFull", 16'(1'b0), 16'(regRdData[StatusFullBit]));
        compareValue("status.readerBusy", 16'(1'b0), 16'(regRdData[StatusBusyBit]));
        @(posedge MCLK);
        #1;

        ptr  = 0;
        stop = 1'b0;
        while (!stop)
        begin
            word = goldenWord(ptr);
            len  = int'(word[9:0]) + 1;
            stimQ.delete();
            expQ.delete();
            if (word == 16'hffff)
            begin
                stop = 1'b1;
            end
            else if (word[15:12] == 4'h0)
            begin
                for (int i = 0; i < len; i++)
                begin
                    entry = goldenWord(ptr + 1 + i);
                    stimQ.push_back(entry[15:8]);
                    expQ.push_back(entry[7:0]);
                end
                runFrame(word[9:0]);
                ptr += len + 1;
            end
            else if (word[15:12] == 4'h1)
            begin
                for (int i = 0; i < len; i++)
                begin
                    stimQ.push_back(fillByte(i));
                    expQ.push_back(fillByte(i));
                end
                runFrame(word[9:0]);
                ptr += 1;
            end
            else if (word[15:12] == 4'h2)
            begin
                runAbort(word[9:0], int'(goldenWord(ptr + 1)));
                ptr += 2;
            end
            else
            begin
                checkCondition(1'b0, "golden file holds an unknown record kind");
                stop = 1'b1;
            end
            if (!stop && ptr >= GoldenDepth - 1)
            begin
                checkCondition(1'b0, "golden file has no end marker");
                stop = 1'b1;
            end
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sipo_golden.txt
// header: kind[15:12] lenMinus1[9:0]; kind 0 lists bytes, 1 fill pattern, 2 abort, ffff ends
// byte line: stimulus byte, expected byte; an abort header is followed by bytes sent before clear
// one byte frame
0000
a5a5
// five byte frame
0004
0101
8080
3c3c
c3c3
7e7e
// full depth frame from the fill pattern
13ff
// abort while capturing
2007
0003
// frame after abort
0002
dede
adad
0f0f
// abort while streaming
2003
0004
// closing frame
0001
1818
e7e7
ffff

//--- filelist.f
sipoPkg.sv
sipoMemIf.sv
ram1k1.sv
sipoBuffer.sv
sipoWriter.sv
sipoReader.sv
sipoCtrlRegs.sv
sipoTop.sv
tbSipoTop.sv

//--- Makefile
VERILATOR ?= verilator
SIMFLAGS  ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall
TOP       ?= tbSipoTop
LINT_TOP  ?= sipoTop
FILELIST  ?= filelist.f
LOG       ?= sim.log
FAIL_MSG  := Regression failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
